//--- data_array.sv
`timescale 1ns/1ps

module data_array
  import icache_pkg::*;
(
  input  logic                 clk,
  input  line_wr_t             wr,
  input  fetch_addr_u          rd_addr,
  input  way_sel_t             rd_way,
  output logic [WORD_BITS-1:0] rd_word
);

  logic [WORD_BITS-1:0] mem [NUM_WAYS][NUM_SETS][LINE_WORDS];

  // One word per refill beat
  always_ff @(posedge clk)
  begin
    if (wr.we)
      mem[wr.way][wr.set][wr.word] <= wr.data;
  end

  assign rd_word = mem[rd_way][rd_addr.fld.index][rd_addr.fld.word];

endmodule

//--- icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
  import icache_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  fetch_addr_u          insaddr,
  output logic [WORD_BITS-1:0] ins,
  output logic                 ok,
  input  lookup_res_t          lookup,
  input  logic [WORD_BITS-1:0] rd_word,
  input  way_sel_t             victim,
  output logic                 touch,
  output way_sel_t             touch_way,
  output fill_req_t            fill,
  input  logic                 crit_beat,
  input  logic [WORD_BITS-1:0] crit_data,
  input  logic                 fill_done,
  output logic                 tag_we,
  output way_sel_t             tag_way,
  output fetch_addr_u          cur_addr
);

  fetch_state_e         state;
  fetch_state_e         state_nxt;
  way_sel_t             fill_way;
  logic                 crit_ok;
  logic [WORD_BITS-1:0] crit_word;
  logic                 hit;
  logic                 miss;

  assign hit  = (state == LOOKUP) && lookup.hit;
  assign miss = (state == LOOKUP) && !lookup.hit;

  ////////////////////////////////
  // Fetch FSM
  ////////////////////////////////

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:    if (req) state_nxt = LOOKUP;
      LOOKUP:  state_nxt = lookup.hit ? IDLE : REFILL;
      REFILL:  if (fill_done) state_nxt = COMMIT;
      COMMIT:  state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state   <= IDLE;
      crit_ok <= 1'b0;
    end
    else
    begin
      state   <= state_nxt;
      crit_ok <= crit_beat;
    end
  end

  // Request, refill way and critical word
  always_ff @(posedge clk)
  begin
    if (state == IDLE && req)
      cur_addr <= insaddr;
    if (miss)
      fill_way <= victim;
    if (crit_beat)
      crit_word <= crit_data;
  end

  ////////////////////////////////
  // Outputs
  ////////////////////////////////

  assign ok  = hit || crit_ok;
  assign ins = crit_ok ? crit_word : rd_word;

  always_comb
  begin
    fill.start = miss;
    fill.way   = victim;
    fill.set   = cur_addr.fld.index;
    fill.crit  = cur_addr.fld.word;
    fill.line  = {cur_addr.fld.tag, cur_addr.fld.index};
  end

  // Refilled way becomes youngest once committed
  assign touch     = hit || (state == COMMIT);
  assign touch_way = (state == COMMIT) ? fill_way : lookup.way;
  assign tag_we    = (state == COMMIT);
  assign tag_way   = fill_way;

endmodule

//--- icache_pkg.sv
package icache_pkg;

  // Cache geometry
  localparam int NUM_WAYS    = 4;
  localparam int NUM_SETS    = 16;
  localparam int LINE_WORDS  = 16;
  localparam int WORD_BITS   = 32;
  localparam int OFFSET_BITS = 4;
  localparam int INDEX_BITS  = 4;
  localparam int TAG_BITS    = 22;
  localparam int WAY_BITS    = 2;
  localparam int AGE_BITS    = 2;

  typedef logic [WAY_BITS-1:0] way_sel_t;

  // Fetch address split into cache fields
  typedef struct packed {
    logic [TAG_BITS-1:0]    tag;
    logic [INDEX_BITS-1:0]  index;
    logic [OFFSET_BITS-1:0] word;
    logic [1:0]             byte_off;
  } fetch_fields_t;

  typedef union packed {
    logic [WORD_BITS-1:0] raw;
    fetch_fields_t        fld;
  } fetch_addr_u;

  typedef struct packed {
    logic     hit;
    way_sel_t way;
  } lookup_res_t;

  // One word written into the data array per refill beat
  typedef struct packed {
    logic                   we;
    way_sel_t               way;
    logic [INDEX_BITS-1:0]  set;
    logic [OFFSET_BITS-1:0] word;
    logic [WORD_BITS-1:0]   data;
  } line_wr_t;

  typedef struct packed {
    logic                           start;
    way_sel_t                       way;
    logic [INDEX_BITS-1:0]          set;
    logic [OFFSET_BITS-1:0]         crit;
    logic [TAG_BITS+INDEX_BITS-1:0] line;
  } fill_req_t;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REFILL,
    COMMIT
  } fetch_state_e;

endpackage

//--- icache_top.f
icache_pkg.sv
line_refill.sv
tag_array.sv
data_array.sv
lru_array.sv
icache_ctrl.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

//--- icache_top.sv
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  fetch_addr_u          insaddr,
  output logic [WORD_BITS-1:0] ins,
  output logic                 ok,
  output logic                 sen,
  output logic [WORD_BITS-1:0] addr,
  input  logic [WORD_BITS-1:0] sdata,
  input  logic                 data_ok
);

  lookup_res_t          lookup;
  logic [WORD_BITS-1:0] rd_word;
  way_sel_t             victim;
  logic                 touch;
  way_sel_t             touch_way;
  fill_req_t            fill;
  logic                 crit_beat;
  logic [WORD_BITS-1:0] crit_data;
  logic                 fill_done;
  logic                 tag_we;
  way_sel_t             tag_way;
  fetch_addr_u          cur_addr;
  line_wr_t             wr;
  logic [NUM_WAYS-1:0]  valid_n;

  icache_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .insaddr   (insaddr),
    .ins       (ins),
    .ok        (ok),
    .lookup    (lookup),
    .rd_word   (rd_word),
    .victim    (victim),
    .touch     (touch),
    .touch_way (touch_way),
    .fill      (fill),
    .crit_beat (crit_beat),
    .crit_data (crit_data),
    .fill_done (fill_done),
    .tag_we    (tag_we),
    .tag_way   (tag_way),
    .cur_addr  (cur_addr)
  );

  line_refill u_refill (
    .clk       (clk),
    .rst       (rst),
    .fill      (fill),
    .sdata     (sdata),
    .data_ok   (data_ok),
    .sen       (sen),
    .addr      (addr),
    .wr        (wr),
    .crit_beat (crit_beat),
    .fill_done (fill_done),
    .crit_data (crit_data)
  );

  tag_array u_tags (
    .clk     (clk),
    .rst     (rst),
    .rd_addr (cur_addr),
    .res     (lookup),
    .tag_we  (tag_we),
    .tag_way (tag_way),
    .valid_n (valid_n)
  );

  data_array u_data (
    .clk     (clk),
    .wr      (wr),
    .rd_addr (cur_addr),
    .rd_way  (lookup.way),
    .rd_word (rd_word)
  );

  lru_array u_lru (
    .clk       (clk),
    .rst       (rst),
    .set_idx   (cur_addr.fld.index),
    .touch     (touch),
    .touch_way (touch_way),
    .valid_n   (valid_n),
    .victim    (victim)
  );

endmodule

//--- line_refill.sv
`timescale 1ns/1ps

module line_refill
  import icache_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  fill_req_t            fill,
  input  logic [WORD_BITS-1:0] sdata,
  input  logic                 data_ok,
  output logic                 sen,
  output logic [WORD_BITS-1:0] addr,
  output line_wr_t             wr,
  output logic                 crit_beat,
  output logic                 fill_done,
  output logic [WORD_BITS-1:0] crit_data
);

  logic [OFFSET_BITS-1:0]         beat_cnt;
  logic [OFFSET_BITS-1:0]         word_ptr;
  way_sel_t                       way;
  logic [INDEX_BITS-1:0]          set;
  logic [TAG_BITS+INDEX_BITS-1:0] line;
  logic                           beat;
  logic                           last_beat;

  assign beat      = sen && data_ok;
  assign last_beat = beat && (beat_cnt == OFFSET_BITS'(LINE_WORDS - 1));

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sen       <= 1'b0;
      beat_cnt  <= '0;
      fill_done <= 1'b0;
    end
    else
    begin
      fill_done <= last_beat;
      if (fill.start)
      begin
        sen      <= 1'b1;
        beat_cnt <= '0;
      end
      else if (beat)
      begin
        beat_cnt <= beat_cnt + 1'b1;
        if (last_beat)
          sen <= 1'b0;
      end
    end
  end

  // Word pointer wraps inside the line
  always_ff @(posedge clk)
  begin
    if (fill.start)
    begin
      way      <= fill.way;
      set      <= fill.set;
      line     <= fill.line;
      word_ptr <= fill.crit;
    end
    else if (beat)
      word_ptr <= word_ptr + 1'b1;
  end

  assign addr = {line, word_ptr, 2'b00};

  always_comb
  begin
    wr.we   = beat;
    wr.way  = way;
    wr.set  = set;
    wr.word = word_ptr;
    wr.data = sdata;
  end

  // First beat carries the requested word
  assign crit_beat = beat && (beat_cnt == '0);
  assign crit_data = sdata;

endmodule

//--- lru_array.sv
`timescale 1ns/1ps

module lru_array
  import icache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [INDEX_BITS-1:0] set_idx,
  input  logic                  touch,
  input  way_sel_t              touch_way,
  input  logic [NUM_WAYS-1:0]   valid_n,
  output way_sel_t              victim
);

  logic [AGE_BITS-1:0] age [NUM_WAYS][NUM_SETS];
  logic [AGE_BITS-1:0] oldest_age;
  way_sel_t            oldest_way;
  way_sel_t            free_way;

  ////////////////////////////////
  // Age update
  ////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < NUM_WAYS; w++)
        for (int s = 0; s < NUM_SETS; s++)
          age[w][s] <= '0;
    end
    else if (touch)
    begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        if (way_sel_t'(w) == touch_way)
          age[w][set_idx] <= '0;
        else if (age[w][set_idx] <= age[touch_way][set_idx] && !(&age[w][set_idx]))
          age[w][set_idx] <= age[w][set_idx] + 1'b1;
      end
    end
  end

  ////////////////////////////////
  // Victim choice
  ////////////////////////////////

  // Strict compare keeps the lowest index on a tie
  always_comb
  begin
    oldest_way = '0;
    oldest_age = age[0][set_idx];
    for (int w = 1; w < NUM_WAYS; w++)
    begin
      if (age[w][set_idx] > oldest_age)
      begin
        oldest_age = age[w][set_idx];
        oldest_way = way_sel_t'(w);
      end
    end
  end

  always_comb
  begin
    free_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--)
      if (valid_n[w])
        free_way = way_sel_t'(w);
  end

  assign victim = (|valid_n) ? free_way : oldest_way;

endmodule

//--- run_sim.sh
#!/bin/bash
# Build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_icache \
  -f icache_top.f -o sim_icache
./obj_dir/sim_icache > sim.log
cat sim.log

if grep -qx "Done: no errors" sim.log
then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- tag_array.sv
`timescale 1ns/1ps

module tag_array
  import icache_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  fetch_addr_u         rd_addr,
  output lookup_res_t         res,
  input  logic                tag_we,
  input  way_sel_t            tag_way,
  output logic [NUM_WAYS-1:0] valid_n
);

  logic [TAG_BITS-1:0] tags  [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] valid [NUM_WAYS];
  logic [NUM_WAYS-1:0] hit_vec;

  always_comb
  begin
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      valid_n[w] = ~valid[w][rd_addr.fld.index];
      hit_vec[w] = valid[w][rd_addr.fld.index] &&
                   (tags[w][rd_addr.fld.index] == rd_addr.fld.tag);
    end
  end

  // Lowest matching way
  always_comb
  begin
    res.hit = |hit_vec;
    res.way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--)
      if (hit_vec[w])
        res.way = way_sel_t'(w);
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < NUM_WAYS; w++)
        valid[w] <= '0;
    end
    else if (tag_we)
      valid[tag_way][rd_addr.fld.index] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (tag_we)
      tags[tag_way][rd_addr.fld.index] <= rd_addr.fld.tag;
  end

endmodule

//--- tb_icache.sv
`timescale 1ns/1ps

module tb_icache
  import icache_pkg::*;
();

  localparam logic [WORD_BITS-1:0] DATA_MASK  = 32'hC3A5_0000;
  localparam int                   WAIT_LIMIT = 400;

  logic                 clk;
  logic                 rst;
  logic                 req;
  fetch_addr_u          insaddr;
  logic [WORD_BITS-1:0] ins;
  logic                 ok;
  logic                 sen;
  logic [WORD_BITS-1:0] addr;
  logic [WORD_BITS-1:0] sdata;
  logic                 data_ok;
  logic [3:0]           max_gap;

  int                   errors;
  int                   beat_total;
  logic                 sen_q;
  fetch_addr_u          req_addr;
  fetch_addr_u          exp_beat;
  logic [AGE_BITS-1:0]  ages    [NUM_WAYS];
  logic [TAG_BITS-1:0]  way_tag [NUM_WAYS];

  icache_top UUT (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .insaddr (insaddr),
    .ins     (ins),
    .ok      (ok),
    .sen     (sen),
    .addr    (addr),
    .sdata   (sdata),
    .data_ok (data_ok)
  );

  tb_mem_model u_mem (
    .clk     (clk),
    .rst     (rst),
    .sen     (sen),
    .addr    (addr),
    .max_gap (max_gap),
    .sdata   (sdata),
    .data_ok (data_ok)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // Checks and helpers
  //////////////////////////////

  function automatic fetch_addr_u make_addr(input logic [TAG_BITS-1:0] tag,
                                            input logic [INDEX_BITS-1:0] set,
                                            input logic [OFFSET_BITS-1:0] word);
    fetch_addr_u a;
    a.fld.tag      = tag;
    a.fld.index    = set;
    a.fld.word     = word;
    a.fld.byte_off = 2'b00;
    return a;
  endfunction

  function automatic logic [WORD_BITS-1:0] mem_word(input fetch_addr_u a);
    return {a.raw[WORD_BITS-1:2], 2'b00} ^ DATA_MASK;
  endfunction

  task automatic check_word(input string name, input logic [WORD_BITS-1:0] exp,
                            input logic [WORD_BITS-1:0] act);
    if (act !== exp)
    begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      errors++;
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d errors, %0d refill beats", errors, beat_total);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  endtask

  task automatic timeout(input string what);
    errors++;
    $display("Timeout at %0t: %s", $time, what);
    finish_run();
  endtask

  // Burst order wraps inside the line from the requested word
  always @(posedge clk)
  begin
    if (rst)
    begin
      sen_q      = 1'b0;
      beat_total = 0;
    end
    else
    begin
      if (sen && !sen_q)
      begin
        exp_beat              = req_addr;
        exp_beat.fld.byte_off = 2'b00;
      end
      if (sen && data_ok)
      begin
        check_word("addr", exp_beat.raw, addr);
        exp_beat.fld.word = exp_beat.fld.word + 4'd1;
        beat_total++;
      end
      sen_q = sen;
    end
  end

  task automatic wait_idle();
    int n;
    n = 0;
    while (UUT.u_ctrl.state != IDLE)
    begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT)
        timeout("controller never returned to IDLE");
    end
  endtask

  task automatic issue(input fetch_addr_u a);
    req      = 1'b1;
    insaddr  = a;
    req_addr = a;
  endtask

  task automatic wait_ok(output logic [WORD_BITS-1:0] data, output int cycles,
                         output logic sen_at);
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT)
        timeout("ok never came back for the fetch request");
    end
    while (!ok);
    data   = ins;
    sen_at = sen;
    req    = 1'b0;
  endtask

  task automatic fetch(input fetch_addr_u a, input logic expect_miss);
    logic [WORD_BITS-1:0] data;
    logic                 sen_at;
    int                   cycles;
    int                   first;
    wait_idle();
    first = beat_total;
    issue(a);
    wait_ok(data, cycles, sen_at);
    check_word("ins", mem_word(a), data);
    // Critical word is answered while the burst is still open
    check_bit("sen", expect_miss, sen_at);
    if (!expect_miss)
      check_word("ok_latency", 32'd1, 32'(cycles));
    wait_idle();
    check_word("beats", expect_miss ? 32'd16 : 32'd0, 32'(beat_total - first));
  endtask

  task automatic age_touch(input int t);
    logic [AGE_BITS-1:0] t_age;
    t_age = ages[t];
    for (int w = 0; w < NUM_WAYS; w++)
      if (w != t && ages[w] <= t_age && ages[w] != '1)
        ages[w] = ages[w] + 2'd1;
    ages[t] = '0;
  endtask

  function automatic int oldest_way();
    int v;
    v = 0;
    for (int w = 1; w < NUM_WAYS; w++)
      if (ages[w] > ages[v])
        v = w;
    return v;
  endfunction

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_cold_miss();
    fetch(make_addr(22'h000A1, 4'd2, 4'd5), 1'b1);
  endtask

  task automatic test_hit_after_fill();
    for (int w = 0; w < LINE_WORDS; w += 2)
      fetch(make_addr(22'h000A1, 4'd2, 4'(w)), 1'b0);
  endtask

  task automatic test_crit_first();
    fetch(make_addr(22'h000B2, 4'd3, 4'd11), 1'b1);
    for (int w = 0; w < LINE_WORDS; w++)
      fetch(make_addr(22'h000B2, 4'd3, 4'(w)), 1'b0);
  endtask

  // Set 7 fills ways 0 to 3 in order
  task automatic test_set_fill();
    for (int i = 0; i < NUM_WAYS; i++)
    begin
      way_tag[i] = 22'h00100 + 22'(i);
      fetch(make_addr(way_tag[i], 4'd7, 4'(3 * i)), 1'b1);
      age_touch(i);
    end
    for (int i = 0; i < NUM_WAYS; i++)
    begin
      fetch(make_addr(way_tag[i], 4'd7, 4'd1), 1'b0);
      age_touch(i);
    end
  endtask

  task automatic test_lru_victim();
    int                  order [6];
    int                  v;
    logic [TAG_BITS-1:0] evicted;
    order = '{2, 0, 3, 1, 0, 2};
    foreach (order[k])
    begin
      fetch(make_addr(way_tag[order[k]], 4'd7, 4'd8), 1'b0);
      age_touch(order[k]);
    end
    v          = oldest_way();
    evicted    = way_tag[v];
    way_tag[v] = 22'h001FF;
    fetch(make_addr(way_tag[v], 4'd7, 4'd14), 1'b1);
    age_touch(v);
    for (int w = 0; w < NUM_WAYS; w++)
      fetch(make_addr(way_tag[w], 4'd7, 4'd2), 1'b0);
    fetch(make_addr(evicted, 4'd7, 4'd2), 1'b1);
  endtask

  task automatic test_busy();
    logic [WORD_BITS-1:0] data;
    logic                 sen_at;
    int                   cycles;
    int                   first;
    max_gap = 4'd9;
    fetch(make_addr(22'h000C3, 4'd9, 4'd6), 1'b1);
    wait_idle();
    first = beat_total;
    issue(make_addr(22'h000D4, 4'd10, 4'd0));
    wait_ok(data, cycles, sen_at);
    check_word("ins", mem_word(make_addr(22'h000D4, 4'd10, 4'd0)), data);
    // Second request is held off until the line is committed
    issue(make_addr(22'h000D4, 4'd10, 4'd13));
    wait_ok(data, cycles, sen_at);
    check_word("ins", mem_word(make_addr(22'h000D4, 4'd10, 4'd13)), data);
    check_bit("sen", 1'b0, sen_at);
    check_word("beats", 32'd16, 32'(beat_total - first));
    wait_idle();
    max_gap = 4'd3;
  endtask

  initial
  begin
    void'($urandom(32'h7539c932));
    errors   = 0;
    rst      = 1'b1;
    req      = 1'b0;
    insaddr  = '0;
    req_addr = '0;
    max_gap  = 4'd3;
    for (int w = 0; w < NUM_WAYS; w++)
      ages[w] = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_bit("ok", 1'b0, ok);
    check_bit("sen", 1'b0, sen);
    test_cold_miss();
    test_hit_after_fill();
    test_crit_first();
    test_set_fill();
    test_lru_victim();
    test_busy();
    finish_run();
  end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
  import icache_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 sen,
  input  logic [WORD_BITS-1:0] addr,
  input  logic [3:0]           max_gap,
  output logic [WORD_BITS-1:0] sdata,
  output logic                 data_ok
);

  localparam logic [WORD_BITS-1:0] DATA_MASK = 32'hC3A5_0000;

  logic [3:0] gap;

  // Beats launch on the falling edge
  always @(negedge clk or posedge rst)
  begin
    if (rst)
    begin
      gap     <= 4'd0;
      sdata   <= '0;
      data_ok <= 1'b0;
    end
    else
    begin
      data_ok <= 1'b0;
      if (sen && gap == 4'd0)
      begin
        data_ok <= 1'b1;
        sdata   <= addr ^ DATA_MASK;
        gap     <= 4'($urandom_range(32'(max_gap)));
      end
      else if (sen)
        gap <= gap - 4'd1;
    end
  end

endmodule
